// File: lsu_pkg.sv
package lsu_pkg;

    localparam int ADDR_W = 32;
    // 4 KB pages
    localparam int VPN_W  = 20;
    localparam int CNT_W  = 32;

    // kseg0/kseg1 top bits
    localparam logic [1:0] SEG_UNMAPPED = 2'b10;
    // cacheable unmapped segment
    localparam logic [2:0] SEG_KSEG0    = 3'b100;

    typedef enum logic [2:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } lsu_op_t;

    typedef enum logic [4:0] {
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_t;

    // translation query sequence
    typedef enum logic [1:0] {
        Q_IDLE,
        Q_QUERY,
        Q_REQUEST
    } qstate_t;

endpackage

// File: lsu_addr_check.sv
module lsu_addr_check import lsu_pkg::*; (
    input  lsu_op_t           op_i,
    input  logic [ADDR_W-1:0] base_i,
    input  logic [15:0]       offset_i,
    output logic [ADDR_W-1:0] eaddr_o,
    output logic              adel_o,
    output logic              ades_o,
    output logic              unmapped_o,
    output logic              kseg0_o,
    output logic              is_store_o
);

    logic [ADDR_W-1:0] offset_sx;
    logic              word_op;
    logic              half_op;
    logic              word_misaligned;
    logic              half_misaligned;

    assign offset_sx = {{(ADDR_W-16){offset_i[15]}}, offset_i};
    assign eaddr_o   = base_i + offset_sx;

    assign is_store_o = (op_i == OP_SB) || (op_i == OP_SH) || (op_i == OP_SW);

    assign word_op = (op_i == OP_LW) || (op_i == OP_SW);
    assign half_op = (op_i == OP_LH) || (op_i == OP_LHU) || (op_i == OP_SH);

    // words need both low bits clear, halfwords only bit 0
    assign word_misaligned = word_op && (eaddr_o[1:0] != 2'b00);
    assign half_misaligned = half_op && eaddr_o[0];

    assign adel_o = !is_store_o && (word_misaligned || half_misaligned);
    assign ades_o = is_store_o && (word_misaligned || half_misaligned);

    // kseg0 and kseg1 bypass the TLB
    assign unmapped_o = eaddr_o[ADDR_W-1 -: 2] == SEG_UNMAPPED;
    assign kseg0_o    = eaddr_o[ADDR_W-1 -: 3] == SEG_KSEG0;

endmodule

// File: lsu_store_format.sv
module lsu_store_format import lsu_pkg::*; (
    input  lsu_op_t           op_i,
    input  logic [1:0]        byte_off_i,
    input  logic [ADDR_W-1:0] wdata_i,
    output logic [3:0]        wstrb_o,
    output logic [ADDR_W-1:0] wdata_o,
    output logic [2:0]        size_o
);

    logic [15:0] half;
    logic [7:0]  byte_data;

    assign half      = wdata_i[15:0];
    assign byte_data = wdata_i[7:0];

    // strobes only for stores
    always_comb begin
        case (op_i)
            OP_SW:   wstrb_o = 4'b1111;
            OP_SH:   wstrb_o = 4'b0011 << byte_off_i;
            OP_SB:   wstrb_o = 4'b0001 << byte_off_i;
            default: wstrb_o = 4'b0000;
        endcase
    end

    // size code, lanes replicated so any offset finds its data
    always_comb begin
        case (op_i)
            OP_LW, OP_SW: begin
                size_o  = 3'd2;
                wdata_o = wdata_i;
            end
            OP_LH, OP_LHU, OP_SH: begin
                size_o  = 3'd1;
                wdata_o = {half, half};
            end
            OP_LB, OP_LBU, OP_SB: begin
                size_o  = 3'd0;
                wdata_o = {byte_data, byte_data, byte_data, byte_data};
            end
            default: begin
                size_o  = 3'd0;
                wdata_o = wdata_i;
            end
        endcase
    end

endmodule

// File: lsu_tlb_fsm.sv
module lsu_tlb_fsm import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid_i,
    input  logic              mapped_i,
    input  logic              hit_i,
    input  logic              done_i,
    input  logic [ADDR_W-1:0] eaddr_i,
    output qstate_t           state_o,
    output logic              fill_o,
    output logic [ADDR_W-1:0] tlb_vaddr_o
);

    qstate_t           state;
    qstate_t           state_next;
    logic              start_query;
    logic [ADDR_W-1:0] vaddr_save;

    // mapped, aligned and not in the translation cache
    assign start_query = (state == Q_IDLE) && valid_i && mapped_i && !hit_i;

    always_comb begin
        case (state)
            Q_IDLE:    state_next = start_query ? Q_QUERY : Q_IDLE;
            Q_QUERY:   state_next = Q_REQUEST;
            Q_REQUEST: state_next = done_i ? Q_IDLE : Q_REQUEST;
            default:   state_next = Q_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= Q_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // word-aligned address kept for the TLB and the later lookup
    always_ff @(posedge clk) begin
        if (start_query) begin
            vaddr_save <= {eaddr_i[ADDR_W-1:2], 2'b00};
        end
    end

    assign state_o     = state;
    assign fill_o      = state == Q_QUERY;
    assign tlb_vaddr_o = vaddr_save;

endmodule

// File: lsu_tlb_cache.sv
module lsu_tlb_cache import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              fill_i,
    input  logic              flush_i,
    input  logic [ADDR_W-1:0] vaddr_i,
    input  logic [ADDR_W-1:0] tlb_paddr_i,
    input  logic              tlb_miss_i,
    input  logic              tlb_invalid_i,
    input  logic              tlb_dirty_i,
    input  logic [2:0]        tlb_cattr_i,
    input  logic              is_store_i,
    output logic              hit_o,
    output logic [VPN_W-1:0]  ppn_o,
    output logic              cached_o,
    output logic              tlb_exc_o,
    output exc_code_t         tlb_code_o,
    output logic              refill_o
);

    logic             entry_valid;
    logic [VPN_W-1:0] entry_vpn;
    logic [VPN_W-1:0] entry_ppn;
    logic             entry_miss;
    logic             entry_invalid;
    logic             entry_dirty;
    logic [2:0]       entry_cattr;
    logic             page_bad;

    // flush wins, a TLB write may have changed the page
    always_ff @(posedge clk) begin
        if (!resetn) begin
            entry_valid <= 1'b0;
        end else if (flush_i) begin
            entry_valid <= 1'b0;
        end else if (fill_i) begin
            entry_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            entry_vpn     <= vaddr_i[ADDR_W-1 -: VPN_W];
            entry_ppn     <= tlb_paddr_i[ADDR_W-1 -: VPN_W];
            entry_miss    <= tlb_miss_i;
            entry_invalid <= tlb_invalid_i;
            entry_dirty   <= tlb_dirty_i;
            entry_cattr   <= tlb_cattr_i;
        end
    end

    assign hit_o    = entry_valid && (entry_vpn == vaddr_i[ADDR_W-1 -: VPN_W]);
    assign ppn_o    = entry_ppn;
    assign cached_o = entry_cattr[0];

    assign page_bad  = entry_miss || entry_invalid;
    assign tlb_exc_o = page_bad || (is_store_i && !entry_dirty);
    assign refill_o  = entry_miss;

    // clean page on a store is a modify fault
    always_comb begin
        if (page_bad) begin
            tlb_code_o = is_store_i ? EXC_TLBS : EXC_TLBL;
        end else begin
            tlb_code_o = EXC_MOD;
        end
    end

endmodule

// File: lsu_wait_counter.sv
module lsu_wait_counter import lsu_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req_i,
    input  logic             addr_ok_i,
    input  logic             is_store_i,
    output logic [CNT_W-1:0] load_wait_o,
    output logic [CNT_W-1:0] store_wait_o
);

    logic stalled;

    assign stalled = req_i && !addr_ok_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            load_wait_o  <= '0;
            store_wait_o <= '0;
        end else if (stalled) begin
            if (is_store_i) begin
                store_wait_o <= store_wait_o + CNT_W'(1);
            end else begin
                load_wait_o <= load_wait_o + CNT_W'(1);
            end
        end
    end

endmodule

// File: lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,

    // instruction side
    input  logic              req_valid_i,
    input  lsu_op_t           req_op_i,
    input  logic [ADDR_W-1:0] req_base_i,
    input  logic [15:0]       req_offset_i,
    input  logic [ADDR_W-1:0] req_wdata_i,
    output logic              req_ready_o,

    // memory side
    output logic              mem_req_o,
    output logic              mem_wr_o,
    output logic              mem_cache_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [2:0]        mem_size_o,
    output logic [3:0]        mem_wstrb_o,
    output logic [ADDR_W-1:0] mem_wdata_o,
    input  logic              mem_addr_ok_i,

    // TLB query, answered in the same cycle
    output logic [ADDR_W-1:0] tlb_vaddr_o,
    input  logic [ADDR_W-1:0] tlb_paddr_i,
    input  logic              tlb_miss_i,
    input  logic              tlb_invalid_i,
    input  logic              tlb_dirty_i,
    input  logic [2:0]        tlb_cattr_i,

    input  logic [2:0]        cfg_k0_i,
    input  logic              tlb_flush_i,

    output logic              exc_valid_o,
    output exc_code_t         exc_code_o,
    output logic              exc_refill_o,
    output logic [ADDR_W-1:0] exc_badvaddr_o,

    output logic [CNT_W-1:0]  load_wait_o,
    output logic [CNT_W-1:0]  store_wait_o
);

    logic [ADDR_W-1:0] eaddr;
    logic              adel;
    logic              ades;
    logic              unmapped;
    logic              kseg0;
    logic              is_store;
    logic              align_err;

    qstate_t           state;
    logic              fill;
    logic              in_idle;
    logic              in_request;
    logic [ADDR_W-1:0] cache_vaddr;

    logic              hit;
    logic [VPN_W-1:0]  ppn;
    logic              cached;
    logic              tlb_exc;
    exc_code_t         tlb_code;
    logic              refill;

    logic              direct;
    logic              trans_ok;
    logic              exc_any;

    lsu_addr_check u_addr_check (
        .op_i       (req_op_i),
        .base_i     (req_base_i),
        .offset_i   (req_offset_i),
        .eaddr_o    (eaddr),
        .adel_o     (adel),
        .ades_o     (ades),
        .unmapped_o (unmapped),
        .kseg0_o    (kseg0),
        .is_store_o (is_store)
    );

    lsu_store_format u_store_format (
        .op_i       (req_op_i),
        .byte_off_i (eaddr[1:0]),
        .wdata_i    (req_wdata_i),
        .wstrb_o    (mem_wstrb_o),
        .wdata_o    (mem_wdata_o),
        .size_o     (mem_size_o)
    );

    assign align_err = adel || ades;

    lsu_tlb_fsm u_tlb_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .valid_i     (req_valid_i),
        .mapped_i    (!unmapped && !align_err),
        .hit_i       (hit),
        .done_i      (req_ready_o),
        .eaddr_i     (eaddr),
        .state_o     (state),
        .fill_o      (fill),
        .tlb_vaddr_o (tlb_vaddr_o)
    );

    assign in_idle    = state == Q_IDLE;
    assign in_request = state == Q_REQUEST;

    // after the query the saved address drives the fill and lookup
    assign cache_vaddr = in_idle ? eaddr : tlb_vaddr_o;

    lsu_tlb_cache u_tlb_cache (
        .clk           (clk),
        .resetn        (resetn),
        .fill_i        (fill),
        .flush_i       (tlb_flush_i),
        .vaddr_i       (cache_vaddr),
        .tlb_paddr_i   (tlb_paddr_i),
        .tlb_miss_i    (tlb_miss_i),
        .tlb_invalid_i (tlb_invalid_i),
        .tlb_dirty_i   (tlb_dirty_i),
        .tlb_cattr_i   (tlb_cattr_i),
        .is_store_i    (is_store),
        .hit_o         (hit),
        .ppn_o         (ppn),
        .cached_o      (cached),
        .tlb_exc_o     (tlb_exc),
        .tlb_code_o    (tlb_code),
        .refill_o      (refill)
    );

    // translation is ready: unmapped or hit in idle, or the filled entry
    assign direct   = in_idle && unmapped;
    assign trans_ok = (in_idle && (unmapped || hit)) || in_request;
    assign exc_any  = (in_idle && align_err) || (trans_ok && !direct && tlb_exc);

    assign mem_req_o   = req_valid_i && trans_ok && !exc_any;
    assign mem_wr_o    = is_store;
    assign mem_cache_o = direct ? (kseg0 && cfg_k0_i[0]) : cached;
    assign mem_addr_o  = direct ? {3'b000, eaddr[ADDR_W-4:0]}
                                : {ppn, eaddr[ADDR_W-VPN_W-1:0]};

    // alignment first, then the TLB cause
    assign exc_valid_o    = req_valid_i && exc_any;
    assign exc_code_o     = adel ? EXC_ADEL : (ades ? EXC_ADES : tlb_code);
    assign exc_refill_o   = exc_valid_o && !align_err && refill;
    assign exc_badvaddr_o = eaddr;

    assign req_ready_o = (mem_req_o && mem_addr_ok_i) || exc_valid_o;

    lsu_wait_counter u_wait_counter (
        .clk          (clk),
        .resetn       (resetn),
        .req_i        (mem_req_o),
        .addr_ok_i    (mem_addr_ok_i),
        .is_store_i   (is_store),
        .load_wait_o  (load_wait_o),
        .store_wait_o (store_wait_o)
    );

endmodule

// File: lsu_properties.sv
module lsu_properties import lsu_pkg::*; (
    input logic              clk,
    input logic              resetn,
    input logic              mem_req_i,
    input logic              mem_addr_ok_i,
    input logic              mem_wr_i,
    input logic              mem_cache_i,
    input logic [ADDR_W-1:0] mem_addr_i,
    input logic [2:0]        mem_size_i,
    input logic [3:0]        mem_wstrb_i,
    input logic [ADDR_W-1:0] mem_wdata_i,
    input logic              exc_valid_i,
    input logic              req_ready_i,
    input qstate_t           state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // a stalled request keeps every field until accepted
    property p_req_hold;
        @(posedge clk) disable iff (!resetn)
        mem_req_i && !mem_addr_ok_i |=> mem_req_i
            && $stable({mem_wr_i, mem_cache_i, mem_addr_i, mem_size_i, mem_wstrb_i, mem_wdata_i});
    endproperty

    a_req_hold: assert property (p_req_hold) else begin
        fail_count++;
        $error("memory request dropped or changed while mem_addr_ok_i was low");
    end

    a_req_or_exc: assert property (@(posedge clk) disable iff (!resetn)
        !(mem_req_i && exc_valid_i)) else begin
        fail_count++;
        $error("memory request and exception raised in the same cycle");
    end

    // a completion ends the access and hands the FSM back to idle
    a_ready_done: assert property (@(posedge clk) disable iff (!resetn)
        req_ready_i |=> state_i == Q_IDLE) else begin
        fail_count++;
        $error("req_ready_o high but the query FSM did not return to idle");
    end

endmodule

// File: tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCESSES   = 16 + 14 + 12 + 24 + 3 + 32;
    localparam int MAX_CYCLES = 4 + ACCESSES * 12 + 50;

    typedef struct packed {
        logic              is_exc;
        logic [4:0]        code;
        logic              refill;
        logic              via_tlb;
        logic [ADDR_W-1:0] eaddr;
        logic              wr;
        logic              cache;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
        logic [3:0]        wstrb;
        logic [ADDR_W-1:0] wdata;
    } expect_t;

    typedef struct packed {
        logic [VPN_W-1:0] ppn;
        logic             miss;
        logic             invalid;
        logic             dirty;
        logic [2:0]       cattr;
    } tlb_entry_t;

    logic              clk;
    logic              resetn;
    logic              req_valid_i;
    lsu_op_t           req_op_i;
    logic [ADDR_W-1:0] req_base_i;
    logic [15:0]       req_offset_i;
    logic [ADDR_W-1:0] req_wdata_i;
    logic              req_ready_o;
    logic              mem_req_o;
    logic              mem_wr_o;
    logic              mem_cache_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic [2:0]        mem_size_o;
    logic [3:0]        mem_wstrb_o;
    logic [ADDR_W-1:0] mem_wdata_o;
    logic              mem_addr_ok_i;
    logic [ADDR_W-1:0] tlb_vaddr_o;
    logic [ADDR_W-1:0] tlb_paddr_i;
    logic              tlb_miss_i;
    logic              tlb_invalid_i;
    logic              tlb_dirty_i;
    logic [2:0]        tlb_cattr_i;
    logic [2:0]        cfg_k0_i;
    logic              tlb_flush_i;
    logic              exc_valid_o;
    exc_code_t         exc_code_o;
    logic              exc_refill_o;
    logic [ADDR_W-1:0] exc_badvaddr_o;
    logic [CNT_W-1:0]  load_wait_o;
    logic [CNT_W-1:0]  store_wait_o;

    logic [31:0]      lfsr = 32'hb879_bdff;
    int unsigned      errors_value = 0;
    int unsigned      errors_other = 0;
    int unsigned      stalls_load = 0;
    int unsigned      stalls_store = 0;
    int               cyc = 0;
    int               start_cyc;
    int               req_lat = 0;
    int               exp_lat;
    int               lat;
    expect_t          cur;
    string            cur_name;
    logic             busy = 1'b0;
    logic             done_seen = 1'b0;
    logic             stall_on = 1'b0;
    logic             cache_ok = 1'b0;
    logic [VPN_W-1:0] cache_vpn;
    tlb_entry_t       tlb_ans;

    lsu_top u_lsu_top (.*);

    bind lsu_top lsu_properties u_props (
        .clk           (clk),
        .resetn        (resetn),
        .mem_req_i     (mem_req_o),
        .mem_addr_ok_i (mem_addr_ok_i),
        .mem_wr_i      (mem_wr_o),
        .mem_cache_i   (mem_cache_o),
        .mem_addr_i    (mem_addr_o),
        .mem_size_i    (mem_size_o),
        .mem_wstrb_i   (mem_wstrb_o),
        .mem_wdata_i   (mem_wdata_o),
        .exc_valid_i   (exc_valid_o),
        .req_ready_i   (req_ready_o),
        .state_i       (state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // page type from the low vpn bits: 5 miss, 6 invalid, 7 clean
    function automatic tlb_entry_t tlb_model(logic [VPN_W-1:0] vpn);
        tlb_entry_t t;
        t.ppn     = vpn ^ 20'h3a5c1;
        t.miss    = vpn[2:0] == 3'd5;
        t.invalid = vpn[2:0] == 3'd6;
        t.dirty   = vpn[2:0] != 3'd7;
        t.cattr   = {2'b01, vpn[3]};
        return t;
    endfunction

    always_comb begin
        tlb_ans       = tlb_model(tlb_vaddr_o[ADDR_W-1 -: VPN_W]);
        tlb_paddr_i   = {tlb_ans.ppn, tlb_vaddr_o[11:0]};
        tlb_miss_i    = tlb_ans.miss;
        tlb_invalid_i = tlb_ans.invalid;
        tlb_dirty_i   = tlb_ans.dirty;
        tlb_cattr_i   = tlb_ans.cattr;
    end

    function automatic expect_t ref_result(lsu_op_t op, logic [31:0] base,
                                           logic [15:0] offset, logic [31:0] wdata,
                                           logic [2:0] k0);
        expect_t    e;
        tlb_entry_t t;
        logic       st;
        logic       bad_align;
        e         = '0;
        e.eaddr   = base + {{16{offset[15]}}, offset};
        st        = op inside {OP_SB, OP_SH, OP_SW};
        e.wr      = st;
        bad_align = (op inside {OP_LW, OP_SW} && e.eaddr[1:0] != 2'b00)
                 || (op inside {OP_LH, OP_LHU, OP_SH} && e.eaddr[0]);
        case (op)
            OP_LW, OP_SW: begin
                e.size  = 3'd2;
                e.wdata = wdata;
            end
            OP_LH, OP_LHU, OP_SH: begin
                e.size  = 3'd1;
                e.wdata = {2{wdata[15:0]}};
            end
            default: begin
                e.size  = 3'd0;
                e.wdata = {4{wdata[7:0]}};
            end
        endcase
        case (op)
            OP_SW:   e.wstrb = 4'b1111;
            OP_SH:   e.wstrb = e.eaddr[1] ? 4'b1100 : 4'b0011;
            OP_SB:   e.wstrb = 4'b0001 << e.eaddr[1:0];
            default: e.wstrb = 4'b0000;
        endcase
        if (bad_align) begin
            e.is_exc = 1'b1;
            e.code   = st ? EXC_ADES : EXC_ADEL;
        end else if (e.eaddr[31:30] == 2'b10) begin
            e.addr  = {3'b000, e.eaddr[28:0]};
            e.cache = (e.eaddr[31:29] == 3'b100) && k0[0];
        end else begin
            t         = tlb_model(e.eaddr[31:12]);
            e.via_tlb = 1'b1;
            if (t.miss || t.invalid) begin
                e.is_exc = 1'b1;
                e.code   = st ? EXC_TLBS : EXC_TLBL;
                e.refill = t.miss;
            end else if (st && !t.dirty) begin
                e.is_exc = 1'b1;
                e.code   = EXC_MOD;
            end else begin
                e.addr  = {t.ppn, e.eaddr[11:0]};
                e.cache = t.cattr[0];
            end
        end
        return e;
    endfunction

    function automatic logic [15:0] aligned_offset(lsu_op_t op);
        logic [15:0] o;
        o = 16'(rand_bits(16));
        if (op inside {OP_LW, OP_SW}) o[1:0] = 2'b00;
        if (op inside {OP_LH, OP_LHU, OP_SH}) o[0] = 1'b0;
        return o;
    endfunction

    // kseg0 or kseg1, far enough from the edges for any offset
    function automatic logic [31:0] unmapped_base();
        logic [31:0] seg;
        seg = rand_bits(1);
        return {2'b10, seg[0], 12'(rand_bits(12)), 1'b1, 16'h0000};
    endfunction

    function automatic logic addr_ok_pick();
        return stall_on ? (rand_bits(2) != 32'd0) : 1'b1;
    endfunction

    task automatic check_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            errors_value++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_name, field, exp_v, act_v);
        end
    endtask

    task automatic run_access(input string name, input lsu_op_t op, input logic [31:0] base,
                              input logic [15:0] offset, input logic [31:0] wdata);
        expect_t e;
        e = ref_result(op, base, offset, wdata, cfg_k0_i);
        @(negedge clk);
        req_lat = 0;
        if (e.via_tlb && !(cache_ok && cache_vpn == e.eaddr[31:12])) begin
            req_lat   = 2;
            cache_ok  = 1'b1;
            cache_vpn = e.eaddr[31:12];
        end
        exp_lat       = stall_on ? -1 : req_lat;
        cur           = e;
        cur_name      = name;
        start_cyc     = cyc;
        done_seen     = 1'b0;
        busy          = 1'b1;
        req_valid_i   = 1'b1;
        req_op_i      = op;
        req_base_i    = base;
        req_offset_i  = offset;
        req_wdata_i   = wdata;
        mem_addr_ok_i = addr_ok_pick();
        do begin
            @(negedge clk);
            if (!done_seen) mem_addr_ok_i = addr_ok_pick();
        end while (!done_seen);
        req_valid_i   = 1'b0;
        busy          = 1'b0;
        mem_addr_ok_i = 1'b1;
    endtask

    always @(posedge clk) begin
        // the request is due from req_lat cycles after valid until its transfer
        if (resetn && busy && !done_seen && !cur.is_exc && !mem_addr_ok_i
                && cyc - start_cyc >= req_lat) begin
            if (cur.wr) stalls_store++;
            else stalls_load++;
        end
        if (resetn && req_ready_o) begin
            assert (busy && !done_seen) else begin
                errors_other++;
                $display("%s: a completion arrived with no access outstanding", cur_name);
            end
            if (busy && !done_seen) begin
                done_seen = 1'b1;
                lat = cyc - start_cyc;
                if (exp_lat >= 0) begin
                    assert (lat == exp_lat) else begin
                        errors_value++;
                        $display("[FAIL] %s latency: expected %0d, actual %0d",
                                 cur_name, exp_lat, lat);
                    end
                end
                if (req_lat == 2) begin
                    check_field("tlb_vaddr", {cur.eaddr[31:2], 2'b00}, tlb_vaddr_o);
                end
                if (cur.is_exc) begin
                    assert (exc_valid_o) else begin
                        errors_other++;
                        $display("%s: a memory request came where an exception was due",
                                 cur_name);
                    end
                    check_field("exc_code", 32'(cur.code), 32'(exc_code_o));
                    check_field("exc_refill", 32'(cur.refill), 32'(exc_refill_o));
                    check_field("badvaddr", cur.eaddr, exc_badvaddr_o);
                end else begin
                    assert (mem_req_o) else begin
                        errors_other++;
                        $display("%s: an exception came where a memory request was due",
                                 cur_name);
                    end
                    check_field("mem_addr", cur.addr, mem_addr_o);
                    check_field("mem_wr", 32'(cur.wr), 32'(mem_wr_o));
                    check_field("mem_cache", 32'(cur.cache), 32'(mem_cache_o));
                    check_field("mem_size", 32'(cur.size), 32'(mem_size_o));
                    check_field("mem_wstrb", 32'(cur.wstrb), 32'(mem_wstrb_o));
                    if (cur.wr) check_field("mem_wdata", cur.wdata, mem_wdata_o);
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d value, %0d other", errors_value, errors_other + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        lsu_op_t          op;
        logic [VPN_W-1:0] vpn;
        logic [31:0]      base;
        req_valid_i   = 1'b0;
        req_op_i      = OP_LB;
        req_base_i    = '0;
        req_offset_i  = '0;
        req_wdata_i   = '0;
        mem_addr_ok_i = 1'b1;
        cfg_k0_i      = 3'b011;
        tlb_flush_i   = 1'b0;
        resetn        = 1'b0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < 16; i++) begin
            cfg_k0_i = (i < 8) ? 3'b011 : 3'b110;
            op = lsu_op_t'(3'(rand_bits(3)));
            run_access("unmapped", op, unmapped_base(), aligned_offset(op), rand_bits(32));
        end

        // every legal offset into one kseg1 word
        base = 32'ha000_1000;
        for (int b = 0; b < 4; b++) begin
            run_access("store_format", OP_SB, base, 16'(b), rand_bits(32));
            run_access("store_format", OP_LB, base, 16'(b), rand_bits(32));
            if (!b[0]) begin
                run_access("store_format", OP_SH, base, 16'(b), rand_bits(32));
                run_access("store_format", OP_LH, base, 16'(b), rand_bits(32));
            end
            if (b == 0) begin
                run_access("store_format", OP_SW, base, 16'(b), rand_bits(32));
                run_access("store_format", OP_LW, base, 16'(b), rand_bits(32));
            end
        end

        base = {1'b0, 19'(rand_bits(19)), 12'h000};
        for (int b = 1; b < 4; b++) begin
            run_access("alignment", OP_LW, base, 16'(b), rand_bits(32));
            run_access("alignment", OP_SW, base, 16'(b), rand_bits(32));
            if (b[0]) begin
                run_access("alignment", OP_LH, base, 16'(b), rand_bits(32));
                run_access("alignment", OP_LHU, base, 16'(b), rand_bits(32));
                run_access("alignment", OP_SH, base, 16'(b), rand_bits(32));
            end
        end

        // low vpn bits walk through every page type
        for (int i = 0; i < 24; i++) begin
            vpn = {1'b0, 16'(rand_bits(16)), 3'(i)};
            op  = lsu_op_t'(3'(rand_bits(3)));
            run_access("mapped", op, {vpn, 12'h000}, aligned_offset(op) & 16'h0fff,
                       rand_bits(32));
        end

        vpn = {1'b0, 16'(rand_bits(16)), 3'd1};
        run_access("cache_fill", OP_LW, {vpn, 12'h000}, 16'h0010, rand_bits(32));
        run_access("cache_hit", OP_SW, {vpn, 12'h000}, 16'h0124, rand_bits(32));
        @(negedge clk);
        tlb_flush_i = 1'b1;
        @(negedge clk);
        tlb_flush_i = 1'b0;
        cache_ok    = 1'b0;
        run_access("cache_flush", OP_LW, {vpn, 12'h000}, 16'h0ff8, rand_bits(32));

        stall_on = 1'b1;
        for (int i = 0; i < 32; i++) begin
            op = lsu_op_t'(3'(rand_bits(3)));
            if (rand_bits(1) != 32'd0) begin
                base = unmapped_base();
            end else begin
                base = {1'b0, 16'h2c4e, 3'(rand_bits(2)), 12'h000};
            end
            run_access("back_pressure", op, base, aligned_offset(op) & 16'h0fff,
                       rand_bits(32));
        end
        stall_on = 1'b0;

        @(negedge clk);
        cur_name = "back_pressure";
        check_field("load_wait", stalls_load, load_wait_o);
        check_field("store_wait", stalls_store, store_wait_o);
        errors_other += u_lsu_top.u_props.fail_count;

        $display("errors: %0d value, %0d other", errors_value, errors_other);
        if (errors_value == 0 && errors_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
lsu_pkg.sv
lsu_addr_check.sv
lsu_store_format.sv
lsu_tlb_fsm.sv
lsu_tlb_cache.sv
lsu_wait_counter.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lsu -f verilog.f -o Vtb_lsu

run: compile
	-./obj_dir/Vtb_lsu +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
